// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_soc_bus
DUT_TOP ?= soc_bus
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_soc_bus.sv ====
`timescale 1ns/10ps

module tb_soc_bus import soc_pkg::*; ();

	localparam int NUM_RAM = 16;
	localparam int NUM_BYTES_A = 6;
	localparam int NUM_BYTES_B = 12;
	localparam int DIV_MAX = 12;
	localparam int NUM_XFERS = 3 * NUM_RAM + 20 + NUM_BYTES_A + NUM_BYTES_B;
	localparam int WATCHDOG_CYCLES = NUM_XFERS * 20 +
		(NUM_BYTES_A + NUM_BYTES_B) * 11 * DIV_MAX + 500;

	logic clk48m;
	logic rst;
	logic mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_wstrb;
	logic mem_ready;
	logic [31:0] mem_rdata;
	logic irq;
	logic [5:0] led;
	logic uart_tx;

	// shadow state of the fabric
	logic [31:0] ram_shadow [RAM_WORDS];
	logic [5:0] led_shadow = 6'd0;
	logic [31:0] div_shadow = UART_DIV_RESET;
	logic [7:0] tx_bytes [$];
	int tx_count = 0;
	int rx_count = 0;

	soc_bus DUT (
		.clk48m    (clk48m),
		.rst       (rst),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.irq       (irq),
		.led       (led),
		.uart_tx   (uart_tx)
	);

	initial begin
		clk48m = 1'b0;
		forever #4 clk48m = ~clk48m;
	end

	task automatic mismatch_stop(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("ERR %s: got %08h expected %08h", name, got, want);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] ram_addr(input logic [RAM_AW-1:0] idx);
		return {REGION_RAM, {(26 - RAM_AW){1'b0}}, idx, 2'b00};
	endfunction

	function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [2:0] offset);
		return {region, 23'd0, offset, 2'b00};
	endfunction

	// expected read word from the shadow state
	function automatic logic [31:0] exp_read(input logic [31:0] addr);
		case (addr[31:28])
			REGION_RAM: return ram_shadow[addr[RAM_AW+1:2]];
			REGION_CTRL: begin
				if (addr[4:2] == CTRL_LED)
					return {26'd0, led_shadow};
				else if (addr[4:2] == CTRL_VERSION)
					return SOC_VERSION;
				else
					return 32'd0;
			end
			REGION_UART: return addr[2] ? div_shadow : 32'd0;
			default: return BUS_ERR_DATA;
		endcase
	endfunction

	function automatic void update_shadow(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		logic [RAM_AW-1:0] w;
		w = addr[RAM_AW+1:2];
		case (addr[31:28])
			REGION_RAM: begin
				for (int i = 0; i < 4; i++) begin
					if (wstrb[i])
						ram_shadow[w][i*8 +: 8] = wdata[i*8 +: 8];
				end
			end
			REGION_CTRL: begin
				if (wstrb[0] && addr[4:2] == CTRL_LED)
					led_shadow = wdata[5:0];
			end
			REGION_UART: begin
				if (addr[2]) begin
					if (|wstrb)
						div_shadow = (wdata < UART_DIV_MIN) ? UART_DIV_MIN : wdata;
				end else if (wstrb[0]) begin
					tx_bytes.push_back(wdata[7:0]);
					tx_count++;
				end
			end
			default: begin
			end
		endcase
	endfunction

	// starts and ends on a falling edge
	task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata, output int cycles);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		@(posedge clk48m);
		cycles = 1;
		while (!mem_ready) begin
			@(posedge clk48m);
			cycles++;
		end
		rdata = mem_rdata;
		@(negedge clk48m);
		mem_valid = 1'b0;
		mem_wstrb = 4'b0000;
	endtask

	// compares every completed transfer against the shadow
	always @(posedge clk48m) begin : bus_monitor
		logic [31:0] want;
		if (!rst && mem_valid && mem_ready) begin
			if (mem_wstrb != 4'b0000) begin
				update_shadow(mem_addr, mem_wdata, mem_wstrb);
			end else if (mem_addr[31:28] == REGION_UART && !mem_addr[2]) begin
				assert (mem_rdata <= FIFO_DEPTH)
					else mismatch_stop("mem_rdata fifo level", mem_rdata, FIFO_DEPTH);
			end else begin
				want = exp_read(mem_addr);
				assert (mem_rdata === want)
					else mismatch_stop("mem_rdata", mem_rdata, want);
			end
		end
	end

	// samples the serial line at bit centers
	initial begin : uart_line_check
		logic [7:0] rx;
		logic [7:0] want;
		int unsigned d;
		@(negedge rst);
		forever begin
			@(negedge uart_tx);
			d = div_shadow;
			repeat (d / 2) @(posedge clk48m);
			assert (uart_tx === 1'b0) else abort_run("uart start bit ended early");
			for (int i = 0; i < 8; i++) begin
				repeat (d) @(posedge clk48m);
				rx[i] = uart_tx;
			end
			repeat (d) @(posedge clk48m);
			assert (uart_tx === 1'b1) else abort_run("uart stop bit is not high");
			if (tx_bytes.size() == 0)
				abort_run("uart frame seen with no byte pending");
			want = tx_bytes.pop_front();
			assert (rx === want)
				else mismatch_stop("uart_tx byte", {24'd0, rx}, {24'd0, want});
			rx_count++;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk48m);
		$display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$fatal(1);
	end

	initial begin : main_seq
		logic [RAM_AW-1:0] idx [NUM_RAM];
		logic [31:0] rd;
		logic [31:0] wd;
		logic [31:0] div_val;
		logic [3:0] strb;
		int cyc;
		bit stalled;
		void'($urandom(33));
		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = 32'd0;
		mem_wdata = 32'd0;
		mem_wstrb = 4'b0000;
		repeat (8) @(posedge clk48m);
		@(negedge clk48m);
		rst = 1'b0;
		@(negedge clk48m);
		assert (mem_ready === 1'b0 && irq === 1'b0)
			else abort_run("ready or irq set after reset");
		assert (led === 6'd0) else mismatch_stop("led", {26'd0, led}, 32'd0);
		assert (uart_tx === 1'b1) else abort_run("uart_tx not idle high after reset");

		// scratch ram full words first then random strobes
		for (int i = 0; i < NUM_RAM; i++) begin
			idx[i] = RAM_AW'($urandom % RAM_WORDS);
			bus_xfer(ram_addr(idx[i]), $urandom, 4'hf, rd, cyc);
			assert (cyc == 2) else mismatch_stop("ram write cycles", 32'(cyc), 32'd2);
		end
		for (int i = 0; i < NUM_RAM; i++) begin
			strb = 4'(1 + $urandom % 15);
			bus_xfer(ram_addr(idx[i]), $urandom, strb, rd, cyc);
		end
		for (int i = 0; i < NUM_RAM; i++) begin
			bus_xfer(ram_addr(idx[i]), 32'd0, 4'b0000, rd, cyc);
			assert (cyc == 2) else mismatch_stop("ram read cycles", 32'(cyc), 32'd2);
		end

		// control registers
		wd = $urandom;
		bus_xfer(reg_addr(REGION_CTRL, CTRL_LED), wd, 4'h1, rd, cyc);
		assert (led === wd[5:0]) else mismatch_stop("led", {26'd0, led}, {26'd0, wd[5:0]});
		bus_xfer(reg_addr(REGION_CTRL, CTRL_LED), 32'd0, 4'b0000, rd, cyc);
		bus_xfer(reg_addr(REGION_CTRL, CTRL_VERSION), $urandom, 4'hf, rd, cyc);
		bus_xfer(reg_addr(REGION_CTRL, CTRL_VERSION), 32'd0, 4'b0000, rd, cyc);
		assert (cyc == 1) else mismatch_stop("ctrl read cycles", 32'(cyc), 32'd1);
		bus_xfer(reg_addr(REGION_CTRL, 3'd3), 32'd0, 4'b0000, rd, cyc);

		// unmapped regions pulse irq in the next cycle only
		for (int i = 0; i < 2; i++) begin
			bus_xfer((i == 0) ? 32'h3000_0010 : 32'hf000_0000, $urandom, 4'(i), rd, cyc);
			assert (cyc == 1) else mismatch_stop("bus error cycles", 32'(cyc), 32'd1);
			@(posedge clk48m);
			assert (irq === 1'b1) else abort_run("irq missing after bus error");
			@(posedge clk48m);
			assert (irq === 1'b0) else abort_run("irq longer than one cycle");
			@(negedge clk48m);
		end

		// divider with clamp
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd0, 4'b0000, rd, cyc);
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd0, 4'hf, rd, cyc);
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd0, 4'b0000, rd, cyc);
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd3, 4'h1, rd, cyc);
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd0, 4'b0000, rd, cyc);
		div_val = 5 + $urandom % (DIV_MAX - 4);
		bus_xfer(reg_addr(REGION_UART, 3'd1), div_val, 4'hf, rd, cyc);
		bus_xfer(reg_addr(REGION_UART, 3'd1), 32'd0, 4'b0000, rd, cyc);

		// short string that never fills the fifo
		for (int i = 0; i < NUM_BYTES_A; i++) begin
			bus_xfer(reg_addr(REGION_UART, 3'd0), $urandom, 4'h1, rd, cyc);
			assert (cyc == 1) else mismatch_stop("uart write cycles", 32'(cyc), 32'd1);
		end
		wait (rx_count == tx_count);
		@(negedge clk48m);

		// overrun the fifo back to back
		stalled = 1'b0;
		for (int i = 0; i < NUM_BYTES_B; i++) begin
			bus_xfer(reg_addr(REGION_UART, 3'd0), $urandom, 4'h1, rd, cyc);
			if (cyc > 1)
				stalled = 1'b1;
		end
		assert (stalled) else abort_run("no stall while the uart fifo was full");
		bus_xfer(reg_addr(REGION_UART, 3'd0), 32'd0, 4'b0000, rd, cyc);
		wait (rx_count == tx_count);
		@(negedge clk48m);
		bus_xfer(reg_addr(REGION_UART, 3'd0), 32'd0, 4'b0000, rd, cyc);
		assert (rd === 32'd0) else mismatch_stop("fifo level after drain", rd, 32'd0);

		if (tx_bytes.size() == 0 && rx_count == NUM_BYTES_A + NUM_BYTES_B) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("uart bytes missing at the end of the run");
			$display("Some tests failed");
			$fatal(1);
		end
	end

endmodule

// ==== verilog.f ====
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/ctrl_regs.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/soc_bus.sv
sim/tb_soc_bus.sv

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/10ps

module bus_decoder import soc_pkg::*; (
	input  logic               clk48m,
	input  logic               rst,
	input  logic               mem_valid,
	input  logic [31:0]        mem_addr,
	input  logic [3:0]         mem_wstrb,
	input  logic [7:0]         mem_wdata,
	input  logic               ram_ready,
	input  logic [31:0]        ram_rdata,
	input  logic [31:0]        ctrl_rdata,
	input  logic               fifo_full,
	input  logic [FIFO_LW-1:0] fifo_level,
	input  logic [31:0]        div_rdata,
	output logic               sel_ram,
	output logic               sel_ctrl,
	output logic               sel_uart_div,
	output logic               fifo_push,
	output logic [7:0]         fifo_wdata,
	output logic               mem_ready,
	output logic [31:0]        mem_rdata,
	output logic               irq
);

	logic sel_uart_dat;
	logic bus_err;
	logic is_read;
	logic dat_wait;

	always_comb begin
		sel_ram = 1'b0;
		sel_ctrl = 1'b0;
		sel_uart_dat = 1'b0;
		sel_uart_div = 1'b0;
		bus_err = 1'b0;
		mem_rdata = BUS_ERR_DATA;
		case (mem_addr[31:28])
			REGION_RAM: begin
				sel_ram = mem_valid;
				mem_rdata = ram_rdata;
			end
			REGION_UART: begin
				// bit 2 picks data or divider register
				if (!mem_addr[2]) begin
					sel_uart_dat = mem_valid;
					mem_rdata = {{(32 - FIFO_LW){1'b0}}, fifo_level};
				end else begin
					sel_uart_div = mem_valid;
					mem_rdata = div_rdata;
				end
			end
			REGION_CTRL: begin
				sel_ctrl = mem_valid;
				mem_rdata = ctrl_rdata;
			end
			default: begin
				// unmapped, finish at once and flag it
				bus_err = mem_valid;
			end
		endcase
	end

	assign is_read = (mem_wstrb == 4'b0000);
	// writes to the data register wait for fifo room
	assign dat_wait = fifo_full && !is_read;

	assign fifo_push = sel_uart_dat && mem_wstrb[0] && !fifo_full;
	assign fifo_wdata = mem_wdata;

	assign mem_ready = ram_ready || sel_ctrl || sel_uart_div ||
		(sel_uart_dat && !dat_wait) || bus_err;

	// one cycle pulse after each bus error
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq <= 1'b0;
		end else begin
			irq <= bus_err;
		end
	end

	// ram must not answer a request that is not there
	assert property (@(posedge clk48m) disable iff (rst) ram_ready |-> sel_ram)
		else $error("ram_ready without sel_ram");

endmodule

// ==== verilog/ctrl_regs.sv ====
`timescale 1ns/10ps

module ctrl_regs import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sel_ctrl,
	input  logic [2:0]  offset,
	input  logic [3:0]  wstrb,
	input  logic [31:0] wdata,
	output logic [5:0]  led,
	output logic [31:0] rdata
);

	logic led_we;

	assign led_we = sel_ctrl && wstrb[0] && (offset == CTRL_LED);

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= 6'd0;
		end else if (led_we) begin
			led <= wdata[5:0];
		end
	end

	// version word is read only
	always_comb begin
		case (offset)
			CTRL_LED:     rdata = {26'd0, led};
			CTRL_VERSION: rdata = SOC_VERSION;
			default:      rdata = 32'd0;
		endcase
	end

endmodule

// ==== verilog/scratch_ram.sv ====
`timescale 1ns/10ps

module scratch_ram import soc_pkg::*; (
	input  logic              clk48m,
	input  logic              rst,
	input  logic              sel_ram,
	input  logic [RAM_AW-1:0] addr,
	input  logic [3:0]        wstrb,
	input  logic [31:0]       wdata,
	output logic              ram_ready,
	output logic [31:0]       rdata
);

	logic [31:0] mem [RAM_WORDS];
	logic access;

	// hold off in the cycle after ready so one request is served once
	assign access = sel_ram && !ram_ready;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ram_ready <= 1'b0;
		end else begin
			ram_ready <= access;
		end
	end

	always_ff @(posedge clk48m) begin
		if (access) begin
			rdata <= mem[addr];
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	assert property (@(posedge clk48m) disable iff (rst) ram_ready |=> !ram_ready)
		else $error("ram_ready held for two cycles");

endmodule

// ==== verilog/soc_bus.sv ====
`timescale 1ns/10ps

module soc_bus import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_wstrb,
	output logic        mem_ready,
	output logic [31:0] mem_rdata,
	output logic        irq,
	output logic [5:0]  led,
	output logic        uart_tx
);

	logic sel_ram;
	logic sel_ctrl;
	logic sel_uart_div;
	logic ram_ready;
	logic [31:0] ram_rdata;
	logic [31:0] ctrl_rdata;
	logic [31:0] div_rdata;
	logic fifo_push;
	logic [7:0] fifo_wdata;
	logic fifo_pop;
	logic [7:0] fifo_rdata;
	logic fifo_full;
	logic fifo_empty;
	logic [FIFO_LW-1:0] fifo_level;

	bus_decoder u_decoder (
		.clk48m       (clk48m),
		.rst          (rst),
		.mem_valid    (mem_valid),
		.mem_addr     (mem_addr),
		.mem_wstrb    (mem_wstrb),
		.mem_wdata    (mem_wdata[7:0]),
		.ram_ready    (ram_ready),
		.ram_rdata    (ram_rdata),
		.ctrl_rdata   (ctrl_rdata),
		.fifo_full    (fifo_full),
		.fifo_level   (fifo_level),
		.div_rdata    (div_rdata),
		.sel_ram      (sel_ram),
		.sel_ctrl     (sel_ctrl),
		.sel_uart_div (sel_uart_div),
		.fifo_push    (fifo_push),
		.fifo_wdata   (fifo_wdata),
		.mem_ready    (mem_ready),
		.mem_rdata    (mem_rdata),
		.irq          (irq)
	);

	// word address from byte address
	scratch_ram u_ram (
		.clk48m    (clk48m),
		.rst       (rst),
		.sel_ram   (sel_ram),
		.addr      (mem_addr[RAM_AW+1:2]),
		.wstrb     (mem_wstrb),
		.wdata     (mem_wdata),
		.ram_ready (ram_ready),
		.rdata     (ram_rdata)
	);

	ctrl_regs u_ctrl (
		.clk48m   (clk48m),
		.rst      (rst),
		.sel_ctrl (sel_ctrl),
		.offset   (mem_addr[4:2]),
		.wstrb    (mem_wstrb),
		.wdata    (mem_wdata),
		.led      (led),
		.rdata    (ctrl_rdata)
	);

	uart_fifo u_fifo (
		.clk48m (clk48m),
		.rst    (rst),
		.push   (fifo_push),
		.wdata  (fifo_wdata),
		.pop    (fifo_pop),
		.rdata  (fifo_rdata),
		.full   (fifo_full),
		.empty  (fifo_empty),
		.level  (fifo_level)
	);

	uart_tx u_uart_tx (
		.clk48m       (clk48m),
		.rst          (rst),
		.sel_uart_div (sel_uart_div),
		.wstrb        (mem_wstrb),
		.wdata        (mem_wdata),
		.fifo_rdata   (fifo_rdata),
		.fifo_empty   (fifo_empty),
		.fifo_pop     (fifo_pop),
		.div_rdata    (div_rdata),
		.txd          (uart_tx)
	);

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	// top address nibble, bits 31:28
	localparam logic [3:0] REGION_UART = 4'h1;
	localparam logic [3:0] REGION_CTRL = 4'h2;
	localparam logic [3:0] REGION_RAM = 4'h4;

	// read word for unmapped accesses
	localparam logic [31:0] BUS_ERR_DATA = 32'hdeadbeef;
	localparam logic [31:0] SOC_VERSION = 32'h0000_8000;

	// scratch ram sizing
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW = 8;

	// uart byte fifo sizing
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;
	localparam int FIFO_LW = 4;

	// clocks per bit
	localparam logic [31:0] UART_DIV_RESET = 32'd16;
	localparam logic [31:0] UART_DIV_MIN = 32'd4;

	// control register offsets, address bits 4:2
	localparam logic [2:0] CTRL_LED = 3'd0;
	localparam logic [2:0] CTRL_VERSION = 3'd1;

endpackage

// ==== verilog/uart_fifo.sv ====
`timescale 1ns/10ps

module uart_fifo import soc_pkg::*; (
	input  logic               clk48m,
	input  logic               rst,
	input  logic               push,
	input  logic [7:0]         wdata,
	input  logic               pop,
	output logic [7:0]         rdata,
	output logic               full,
	output logic               empty,
	output logic [FIFO_LW-1:0] level
);

	logic [7:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wptr;
	logic [FIFO_AW-1:0] rptr;

	always_ff @(posedge clk48m) begin
		if (push) begin
			mem[wptr] <= wdata;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			level <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
			// both at once keeps the level
			if (push && !pop) begin
				level <= level + 1'b1;
			end else if (pop && !push) begin
				level <= level - 1'b1;
			end
		end
	end

	// head byte, taken by the reader on pop
	assign rdata = mem[rptr];
	assign full = (level == FIFO_LW'(FIFO_DEPTH));
	assign empty = (level == '0);

	assert property (@(posedge clk48m) disable iff (rst) full |-> !push)
		else $error("push into full fifo");
	assert property (@(posedge clk48m) disable iff (rst) empty |-> !pop)
		else $error("pop from empty fifo");

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sel_uart_div,
	input  logic [3:0]  wstrb,
	input  logic [31:0] wdata,
	input  logic [7:0]  fifo_rdata,
	input  logic        fifo_empty,
	output logic        fifo_pop,
	output logic [31:0] div_rdata,
	output logic        txd
);

	logic [31:0] div;
	logic [31:0] cyc_cnt;
	logic [3:0] bit_cnt;
	// data bits then stop bit shifted out lsb first
	logic [8:0] shreg;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			div <= UART_DIV_RESET;
		end else if (sel_uart_div && (|wstrb)) begin
			div <= (wdata < UART_DIV_MIN) ? UART_DIV_MIN : wdata;
		end
	end

	assign div_rdata = div;

	// idle when no bits left
	assign fifo_pop = (bit_cnt == 4'd0) && !fifo_empty;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			bit_cnt <= 4'd0;
			cyc_cnt <= 32'd0;
			shreg <= '1;
			txd <= 1'b1;
		end else if (fifo_pop) begin
			// start bit goes out now
			txd <= 1'b0;
			shreg <= {1'b1, fifo_rdata};
			bit_cnt <= 4'd10;
			cyc_cnt <= div - 1'b1;
		end else if (bit_cnt != 4'd0) begin
			if (cyc_cnt == 32'd0) begin
				txd <= shreg[0];
				shreg <= {1'b1, shreg[8:1]};
				bit_cnt <= bit_cnt - 1'b1;
				cyc_cnt <= div - 1'b1;
			end else begin
				cyc_cnt <= cyc_cnt - 1'b1;
			end
		end
	end

	// line idles high between frames
	assert property (@(posedge clk48m) disable iff (rst) (bit_cnt == 4'd0) |-> txd)
		else $error("uart line not idle between frames");

endmodule
